/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= tb_outrun_main
FILELIST  ?= list.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* list.f */
outrun_pkg.sv
outrun_ppi.sv
outrun_motor.sv
outrun_bus_ctrl.sv
outrun_cab_io.sv
outrun_main.sv
tb_outrun_main.sv

/* outrun_bus_ctrl.sv */
//********************************************************************
// Host bus sequencer with registered chip selects and read mux.
// Four-phase req/ack; ROM and RAM/VRAM wait for their ok.
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module outrun_bus_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 req,
    input  outrun_pkg::addr_t   addr,
    input  wire                 rnw,
    input  outrun_pkg::dsn_t    dsn,
    input  outrun_pkg::word_t   rom_data,
    input  outrun_pkg::word_t   ram_data,   // Shared by RAM and VRAM
    input  outrun_pkg::word_t   char_dout,
    input  outrun_pkg::word_t   pal_dout,
    input  outrun_pkg::word_t   obj_dout,
    input  wire                 rom_ok,
    input  wire                 ram_ok,
    input  outrun_pkg::byte_t   cab_dout,
    output logic                ack,
    output outrun_pkg::word_t   rdata,
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    output logic                char_cs,
    output logic                pal_cs,
    output logic                objram_cs,
    output logic                io_cs,
    output logic                acc_stb
);
    import outrun_pkg::*;

    region_e region;
    logic    strobe, busy, slow_cs, slow_ok, go;
    word_t   rd_mux;

    assign region  = region_e'(addr[23:20]);
    assign strobe  = ~&dsn;
    assign slow_cs = rom_cs | ram_cs | vram_cs;
    assign slow_ok = (rom_cs & rom_ok) | ((ram_cs | vram_cs) & ram_ok);
    // Access completes this cycle
    assign go = req & busy & ~ack & (slow_cs ? slow_ok : 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs} <= '0;
            busy    <= 1'b0;
            ack     <= 1'b0;
            acc_stb <= 1'b0;
        end else begin
            acc_stb <= go;
            if (!req) begin
                {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs} <= '0;
                busy <= 1'b0;
                ack  <= 1'b0;
            end else if (!busy) begin
                busy      <= 1'b1;
                ram_cs    <= region == REG_MEM && addr[18:17] == 2'b11 && strobe;
                rom_cs    <= region == REG_MEM && !(addr[18:17] == 2'b11 && strobe);
                char_cs   <= region == REG_SCR &&  addr[16] && strobe;
                vram_cs   <= region == REG_SCR && !addr[16] && strobe;
                pal_cs    <= region == REG_PAL;
                objram_cs <= region == REG_OBJ;
                io_cs     <= region == REG_IO;
            end else if (go) begin
                ack <= 1'b1;
            end
        end
    end

    always_comb begin
        if (rom_cs)                rd_mux = rom_data;
        else if (ram_cs | vram_cs) rd_mux = ram_data;
        else if (char_cs)          rd_mux = char_dout;
        else if (pal_cs)           rd_mux = pal_dout;
        else if (objram_cs)        rd_mux = obj_dout;
        else if (io_cs)            rd_mux = {8'hFF, cab_dout};
        else                       rd_mux = UNMAPPED_DATA;
    end

    // Held until the next read completes
    always_ff @(posedge clk) begin
        if (go && rnw) rdata <= rd_mux;
    end

    a_cs_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs}));

    a_ack_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(req));

endmodule

`default_nettype wire

/* outrun_cab_io.sv */
//********************************************************************
// Out Run cabinet I/O: switches, DIPs, ADC, mute, object toggle and
// board controls from the PPI. Writes land on acc_stb.
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module outrun_cab_io #(
    parameter outrun_pkg::word_t MOTOR_MIN = outrun_pkg::MOTOR_MIN,
    parameter outrun_pkg::word_t MOTOR_MAX = outrun_pkg::MOTOR_MAX
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 io_cs,
    input  wire                 acc_stb,
    input  outrun_pkg::addr_t   addr,
    input  wire                 rnw,
    input  outrun_pkg::dsn_t    dsn,
    input  outrun_pkg::word_t   wdata,
    input  wire                 vint,
    input  wire  [2:0]          ctrl_type,
    input  outrun_pkg::byte_t   joystick1,
    input  outrun_pkg::word_t   joyana1,
    input  outrun_pkg::word_t   joyana1b,
    input  wire  [1:0]          start_button,
    input  wire  [1:0]          coin_input,
    input  wire                 service,
    input  wire                 dip_test,
    input  outrun_pkg::byte_t   dipsw_a,
    input  outrun_pkg::byte_t   dipsw_b,
    output outrun_pkg::byte_t   cab_dout,
    output logic                mute,
    output logic                obj_toggle,
    output logic                video_en,
    output logic                snd_rstb,
    output logic [1:0]          obj_cfg,
    output logic [2:0]          adc_ch
);
    import outrun_pkg::*;

    logic [2:0] sub, motor_lim;
    logic       wr_lo, ppi_sel;
    byte_t      ppi_dout, ppib_dout, ppic_dout, sw_dout, adc_dout;
    word_t      ana_a, ana_b, motor_pos;

    assign sub     = addr[6:4];
    assign wr_lo   = ~rnw & ~dsn[0];
    assign ppi_sel = io_cs & (sub == IO_PPI);

    // Inverted pedal reading, zero below half travel
    function automatic byte_t pedal_inv(input word_t v);
        return v[15] ? ~{v[14:8], v[14]} : 8'h00;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mute <= 1'b0;
        end else if (acc_stb && io_cs && sub == IO_MUTE && wr_lo) begin
            mute <= ~wdata[7];   // Darlington inverter on the amp
        end
    end

    always_ff @(posedge clk) begin
        if (acc_stb && io_cs && sub == IO_ADC && !rnw) begin
            ana_a <= joyana1;
            ana_b <= joyana1b;
        end
    end

    always_comb begin
        case (addr[2:1])
            2'd0: sw_dout = {coin_input, ~joystick1[7], joystick1[6],
                             start_button[0], service, dip_test, 1'b1};
            2'd2:    sw_dout = dipsw_a;
            2'd3:    sw_dout = dipsw_b;
            default: sw_dout = 8'hFF;
        endcase
    end

    always_comb begin
        adc_dout = 8'hFF;   // Channels 4-7 float high
        case (adc_ch)
            ADC_WHEEL: begin
                adc_dout = ana_a[7:0] ^ 8'h80;
                if (!joystick1[0]) adc_dout = 8'hE0;   // Digital left/right
                if (!joystick1[1]) adc_dout = 8'h20;
            end
            ADC_GAS: begin
                case (ctrl_type)
                    3'd0:    adc_dout = pedal_inv(ana_b);
                    3'd1:    adc_dout = ana_b[7] ? 8'h00 : {ana_b[6:0], ana_b[6]};
                    3'd2:    adc_dout = pedal_inv(ana_a);   // Wheel pedals
                    default: adc_dout = 8'h00;
                endcase
                if (!joystick1[4]) adc_dout = 8'hFF;
            end
            ADC_BRAKE: begin
                case (ctrl_type)
                    3'd0, 3'd1: adc_dout = ana_b[15] ? 8'h00 : {ana_b[14:8], ana_b[14]};
                    3'd2:       adc_dout = pedal_inv(ana_b);
                    default:    adc_dout = 8'h00;
                endcase
                if (!joystick1[5]) adc_dout = 8'hFF;
            end
            ADC_MOTOR: adc_dout = motor_pos[15:8];
            default: ;
        endcase
    end

    always_comb begin
        case (sub)
            IO_PPI:  cab_dout = ppi_dout;
            IO_SW:   cab_dout = sw_dout;
            IO_ADC:  cab_dout = adc_dout;
            default: cab_dout = 8'hFF;
        endcase
    end

    assign obj_toggle = io_cs & acc_stb & (sub == IO_TOGGLE);

    // Board controls on port C
    assign obj_cfg  = ppic_dout[7:6];
    assign video_en = ppic_dout[5];
    assign adc_ch   = ppic_dout[4:2];
    assign snd_rstb = ppic_dout[0];

    outrun_ppi u_ppi (
        .clk        (clk),
        .rst        (rst),
        .sel        (ppi_sel),
        .port_addr  (addr[2:1]),
        .we         (acc_stb & wr_lo),
        .wdata      (wdata[7:0]),
        .porta_din  ({2'b00, motor_lim, 3'b111}),
        .rdata      (ppi_dout),
        .portb_dout (ppib_dout),
        .portc_dout (ppic_dout)
    );

    outrun_motor #(
        .MOTOR_MIN (MOTOR_MIN),
        .MOTOR_MAX (MOTOR_MAX)
    ) u_motor (
        .clk    (clk),
        .rst    (rst),
        .vint   (vint),
        .ctrl   (ppib_dout),
        .pos    (motor_pos),
        .limpos (motor_lim)
    );

endmodule

`default_nettype wire

/* outrun_main.sv */
//********************************************************************
// Main board glue top level: bus controller plus Out Run cabinet I/O.
// The host drives the four-phase bus in place of the CPU.
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module outrun_main (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 vint,
    // Host bus
    input  wire                 req,
    input  outrun_pkg::addr_t   addr,
    input  wire                 rnw,
    input  outrun_pkg::word_t   wdata,
    input  outrun_pkg::dsn_t    dsn,
    output logic                ack,
    output outrun_pkg::word_t   rdata,
    // Memories
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    input  outrun_pkg::word_t   rom_data,
    input  outrun_pkg::word_t   ram_data,
    input  wire                 rom_ok,
    input  wire                 ram_ok,
    // Video
    output logic                char_cs,
    output logic                pal_cs,
    output logic                objram_cs,
    input  outrun_pkg::word_t   char_dout,
    input  outrun_pkg::word_t   pal_dout,
    input  outrun_pkg::word_t   obj_dout,
    // Cabinet
    input  wire  [2:0]          ctrl_type,
    input  outrun_pkg::byte_t   joystick1,
    input  outrun_pkg::word_t   joyana1,
    input  outrun_pkg::word_t   joyana1b,
    input  wire  [1:0]          start_button,
    input  wire  [1:0]          coin_input,
    input  wire                 service,
    input  wire                 dip_test,
    input  outrun_pkg::byte_t   dipsw_a,
    input  outrun_pkg::byte_t   dipsw_b,
    // Board controls
    output logic                mute,
    output logic                obj_toggle,
    output logic                video_en,
    output logic                snd_rstb,
    output logic [1:0]          obj_cfg,
    output logic [2:0]          adc_ch
);
    import outrun_pkg::*;

    logic  io_cs, acc_stb;
    byte_t cab_dout;

    outrun_bus_ctrl u_bus (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .rnw       (rnw),
        .dsn       (dsn),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .cab_dout  (cab_dout),
        .ack       (ack),
        .rdata     (rdata),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .acc_stb   (acc_stb)
    );

    outrun_cab_io #(
        .MOTOR_MIN (MOTOR_MIN),   // Cabinet travel limits
        .MOTOR_MAX (MOTOR_MAX)
    ) u_cab (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .acc_stb      (acc_stb),
        .addr         (addr),
        .rnw          (rnw),
        .dsn          (dsn),
        .wdata        (wdata),
        .vint         (vint),
        .ctrl_type    (ctrl_type),
        .joystick1    (joystick1),
        .joyana1      (joyana1),
        .joyana1b     (joyana1b),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .mute         (mute),
        .obj_toggle   (obj_toggle),
        .video_en     (video_en),
        .snd_rstb     (snd_rstb),
        .obj_cfg      (obj_cfg),
        .adc_ch       (adc_ch)
    );

endmodule

`default_nettype wire

/* outrun_motor.sv */
//********************************************************************
// Steering motor model. Position steps once per frame by the port B
// drive and stops at the end switches.
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module outrun_motor #(
    parameter outrun_pkg::word_t MOTOR_MIN = outrun_pkg::MOTOR_MIN,
    parameter outrun_pkg::word_t MOTOR_MAX = outrun_pkg::MOTOR_MAX
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 vint,
    input  outrun_pkg::byte_t   ctrl,
    output outrun_pkg::word_t   pos,
    output logic [2:0]          limpos
);
    import outrun_pkg::*;

    logic               vint_l;
    logic signed [17:0] step, sum;
    word_t              nxt;

    assign step = {{2{ctrl[7]}}, ctrl, 8'h00};   // Signed drive x 256
    assign sum  = $signed({2'b00, pos}) + step;

    always_comb begin
        if (sum < $signed({2'b00, MOTOR_MIN}))      nxt = MOTOR_MIN;
        else if (sum > $signed({2'b00, MOTOR_MAX})) nxt = MOTOR_MAX;
        else                                        nxt = sum[15:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_l <= 1'b0;
            pos    <= MOTOR_CENTRE;
        end else begin
            vint_l <= vint;
            if (vint && !vint_l) pos <= nxt;
        end
    end

    assign limpos[0] = pos == MOTOR_MIN;
    assign limpos[1] = pos[15:8] == 8'h80;   // Centre sensor
    assign limpos[2] = pos == MOTOR_MAX;

    a_pos_range: assert property (@(posedge clk) disable iff (rst)
        pos >= MOTOR_MIN && pos <= MOTOR_MAX);

endmodule

`default_nettype wire

/* outrun_pkg.sv */
//********************************************************************
// Shared types, fixed region map and cabinet constants for the glue
// logic. Modules import it inside their bodies.
//********************************************************************
`default_nettype none

package outrun_pkg;

    typedef logic [23:1] addr_t;     // Word address
    typedef logic [15:0] word_t;
    typedef logic [ 7:0] byte_t;
    typedef logic [ 1:0] dsn_t;      // {UDSn, LDSn}

    // Region code from address bits 23:20
    typedef enum logic [3:0] {
        REG_MEM = 4'd0,
        REG_SCR = 4'd1,
        REG_PAL = 4'd2,
        REG_OBJ = 4'd3,
        REG_IO  = 4'd4
    } region_e;

    // I/O sub-regions, address bits 6:4
    localparam logic [2:0] IO_PPI    = 3'd0;
    localparam logic [2:0] IO_SW     = 3'd1;
    localparam logic [2:0] IO_MUTE   = 3'd2;
    localparam logic [2:0] IO_ADC    = 3'd3;
    localparam logic [2:0] IO_TOGGLE = 3'd7;  // 6 is the watchdog, not decoded

    localparam logic [2:0] ADC_WHEEL = 3'd0;
    localparam logic [2:0] ADC_GAS   = 3'd1;
    localparam logic [2:0] ADC_BRAKE = 3'd2;
    localparam logic [2:0] ADC_MOTOR = 3'd3;

    // Video enable and sound reset released out of reset
    localparam byte_t PPI_C_RESET = 8'h21;
    localparam byte_t PPI_B_RESET = 8'h00;   // Motor idle

    localparam word_t MOTOR_MIN    = 16'h2000;
    localparam word_t MOTOR_MAX    = 16'hE000;
    localparam word_t MOTOR_CENTRE = 16'h8000;

    localparam word_t UNMAPPED_DATA = 16'hFFFF;

endpackage

`default_nettype wire

/* outrun_ppi.sv */
//********************************************************************
// Reduced 8255: port A input, ports B and C output, port C bit
// set/reset. Mode words are ignored.
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module outrun_ppi (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 sel,
    input  wire  [1:0]          port_addr,
    input  wire                 we,
    input  outrun_pkg::byte_t   wdata,
    input  outrun_pkg::byte_t   porta_din,
    output outrun_pkg::byte_t   rdata,
    output outrun_pkg::byte_t   portb_dout,
    output outrun_pkg::byte_t   portc_dout
);
    import outrun_pkg::*;

    always_comb begin
        case (port_addr)
            2'd0:    rdata = porta_din;
            2'd1:    rdata = portb_dout;
            2'd2:    rdata = portc_dout;
            default: rdata = 8'hFF;   // Control word not readable
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            portb_dout <= PPI_B_RESET;
            portc_dout <= PPI_C_RESET;
        end else if (sel && we) begin
            case (port_addr)
                2'd1: portb_dout <= wdata;
                2'd2: portc_dout <= wdata;
                2'd3: begin
                    // Bit set/reset; mode set (bit 7) dropped
                    if (!wdata[7]) portc_dout[wdata[3:1]] <= wdata[0];
                end
                default: ;  // Port A is input only
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_outrun_main.sv */
//********************************************************************
// Directed testbench for the main-board glue top level. Runs memory
// map, switch, control, ADC and motor tests over the host bus.
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_outrun_main;
    import outrun_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;   // Whole run needs under 2000

    logic clk, rst, vint, req, rnw, rom_ok, ram_ok;
    addr_t addr;
    word_t wdata, rdata, rom_data, ram_data, char_dout, pal_dout, obj_dout;
    dsn_t dsn;
    logic ack, rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    logic [2:0] ctrl_type, adc_ch;
    byte_t joystick1, dipsw_a, dipsw_b;
    word_t joyana1, joyana1b;
    logic [1:0] start_button, coin_input, obj_cfg;
    logic service, dip_test, mute, obj_toggle, video_en, snd_rstb;

    logic [31:0] lfsr = 32'he588;
    int errors = 0;
    int cycles = 0;
    int toggle_count = 0;
    word_t mpos;            // Expected motor position
    int rom_cnt, ram_cnt;
    logic rom_armed, ram_armed;

    outrun_main dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Memory contents depend on every address bit
    function automatic word_t fill(input addr_t a, input word_t salt);
        return a[16:1] ^ {a[23:17], 9'h0} ^ salt;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ROM model with random ok delay
    always @(posedge clk) begin
        rom_data <= fill(addr, 16'h1234);
        if (!rom_cs) begin
            rom_ok <= 1'b0;
            rom_armed = 1'b0;
        end else if (!rom_armed) begin
            rom_cnt = int'(rand_bits(2));
            rom_armed = 1'b1;
            if (rom_cnt == 0) rom_ok <= 1'b1;
        end else if (rom_cnt > 0) begin
            rom_cnt--;
            if (rom_cnt == 0) rom_ok <= 1'b1;
        end
    end

    // RAM and VRAM share one model
    always @(posedge clk) begin
        ram_data  <= fill(addr, 16'h5A5A);
        char_dout <= fill(addr, 16'hC3C3);
        pal_dout  <= fill(addr, 16'h0F0F);
        obj_dout  <= fill(addr, 16'h6699);
        if (!(ram_cs | vram_cs)) begin
            ram_ok <= 1'b0;
            ram_armed = 1'b0;
        end else if (!ram_armed) begin
            ram_cnt = int'(rand_bits(2));
            ram_armed = 1'b1;
            if (ram_cnt == 0) ram_ok <= 1'b1;
        end else if (ram_cnt > 0) begin
            ram_cnt--;
            if (ram_cnt == 0) ram_ok <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (obj_toggle) toggle_count++;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    // One four-phase access; records every chip select seen
    task automatic host_access(input logic [23:0] baddr, input logic write, input word_t wd,
                               input dsn_t ds, output word_t rd, output byte_t cs_seen);
        @(posedge clk);
        req   <= 1'b1;
        addr  <= baddr[23:1];
        rnw   <= ~write;
        wdata <= wd;
        dsn   <= ds;
        cs_seen = '0;
        do begin
            @(negedge clk);
            cs_seen |= {2'b00, rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};
        end while (!ack);
        rd = rdata;
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack);
    endtask

    task automatic bus_read(input logic [23:0] baddr, output word_t rd);
        byte_t cs;
        host_access(baddr, 1'b0, 16'h0, 2'b00, rd, cs);
    endtask

    task automatic bus_write(input logic [23:0] baddr, input word_t wd);
        word_t rd;
        byte_t cs;
        host_access(baddr, 1'b1, wd, 2'b00, rd, cs);
    endtask

    function automatic logic [23:0] io_addr(input logic [2:0] sub, input logic [1:0] idx);
        return 24'h400000 | (24'(sub) << 4) | (24'(idx) << 1);
    endfunction

    task automatic write_portc(input byte_t v);
        bus_write(io_addr(IO_PPI, 2'd2), {8'h00, v});
    endtask

    function automatic byte_t adc_expect(input logic [2:0] ch, input logic [2:0] ty,
                                         input word_t a, input word_t b, input byte_t joy);
        byte_t r;
        r = 8'hFF;
        if (ch == ADC_WHEEL) begin
            r = a[7:0] ^ 8'h80;
            if (!joy[0]) r = 8'hE0;
            if (!joy[1]) r = 8'h20;
        end else if (ch == ADC_GAS) begin
            if (ty == 3'd0)      r = b[15] ? ~{b[14:8], b[14]} : 8'h00;
            else if (ty == 3'd1) r = b[7] ? 8'h00 : {b[6:0], b[6]};
            else if (ty == 3'd2) r = a[15] ? ~{a[14:8], a[14]} : 8'h00;
            else                 r = 8'h00;
            if (!joy[4]) r = 8'hFF;
        end else if (ch == ADC_BRAKE) begin
            if (ty <= 3'd1)      r = b[15] ? 8'h00 : {b[14:8], b[14]};
            else if (ty == 3'd2) r = b[15] ? ~{b[14:8], b[14]} : 8'h00;
            else                 r = 8'h00;
            if (!joy[5]) r = 8'hFF;
        end
        return r;
    endfunction

    task automatic reset_values;
        @(negedge clk);
        check_byte("ack", {7'b0, ack}, 8'h00);
        check_byte("chip selects", {2'b0, rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs},
                   8'h00);
        check_byte("mute", {7'b0, mute}, 8'h00);
        check_byte("obj_toggle", {7'b0, obj_toggle}, 8'h00);
        check_byte("video_en", {7'b0, video_en}, 8'h01);
        check_byte("snd_rstb", {7'b0, snd_rstb}, 8'h01);
        check_byte("obj_cfg", {6'b0, obj_cfg}, 8'h00);
        check_byte("adc_ch", {5'b0, adc_ch}, 8'h00);
    endtask

    task automatic map_read(input logic [23:0] baddr, input byte_t exp_cs, input word_t exp);
        word_t rd;
        byte_t cs;
        host_access(baddr, 1'b0, 16'h0, 2'b00, rd, cs);
        check_byte("chip selects", cs, exp_cs);
        check_word("rdata", rd, exp);
    endtask

    task automatic memory_map_reads;
        logic [23:0] a;
        logic [23:0] r;
        for (int i = 0; i < 4; i++) begin
            a = 24'(rand_bits(16)) << 1;   // Within the ROM area
            map_read(a, 8'h20, fill(a[23:1], 16'h1234));
            r = 24'h060000 | {8'h00, a[15:0]};
            map_read(r, 8'h10, fill(r[23:1], 16'h5A5A));
        end
        map_read(24'h100246, 8'h08, fill(addr_t'(24'h100246 >> 1), 16'h5A5A));
        map_read(24'h11048A, 8'h04, fill(addr_t'(24'h11048A >> 1), 16'hC3C3));
        map_read(24'h200100, 8'h02, fill(addr_t'(24'h200100 >> 1), 16'h0F0F));
        map_read(24'h3007FE, 8'h01, fill(addr_t'(24'h3007FE >> 1), 16'h6699));
        map_read(24'h500010, 8'h00, UNMAPPED_DATA);
    endtask

    task automatic switch_and_control_io;
        word_t rd;
        int tc;
        @(posedge clk);
        coin_input   <= 2'b10;
        joystick1    <= 8'h40;
        start_button <= 2'b01;
        service      <= 1'b0;
        dip_test     <= 1'b1;
        dipsw_a      <= 8'h5C;
        dipsw_b      <= 8'hA3;
        bus_read(io_addr(IO_SW, 2'd0), rd);
        check_word("switch 0", rd, 16'hFFBB);   // Coin 10, ~j7, j6, start, svc, test, 1
        bus_read(io_addr(IO_SW, 2'd1), rd);
        check_word("switch 1", rd, 16'hFFFF);
        bus_read(io_addr(IO_SW, 2'd2), rd);
        check_word("dipsw_a", rd, 16'hFF5C);
        bus_read(io_addr(IO_SW, 2'd3), rd);
        check_word("dipsw_b", rd, 16'hFFA3);
        write_portc(8'hC2);
        check_byte("obj_cfg", {6'b0, obj_cfg}, 8'h03);
        check_byte("video_en", {7'b0, video_en}, 8'h00);
        check_byte("snd_rstb", {7'b0, snd_rstb}, 8'h00);
        bus_write(io_addr(IO_PPI, 2'd3), 16'h000B);   // Set bit 5
        bus_write(io_addr(IO_PPI, 2'd3), 16'h0001);   // Set bit 0
        bus_write(io_addr(IO_PPI, 2'd3), 16'h000E);   // Clear bit 7
        bus_write(io_addr(IO_PPI, 2'd3), 16'h0085);   // Mode word, ignored
        bus_write(io_addr(IO_PPI, 2'd3), 16'h0009);   // Set bit 4
        check_byte("obj_cfg", {6'b0, obj_cfg}, 8'h01);
        check_byte("video_en", {7'b0, video_en}, 8'h01);
        check_byte("adc_ch", {5'b0, adc_ch}, 8'h04);
        check_byte("snd_rstb", {7'b0, snd_rstb}, 8'h01);
        bus_read(io_addr(IO_PPI, 2'd2), rd);
        check_word("port C", rd, 16'hFF73);
        bus_write(io_addr(IO_PPI, 2'd1), 16'h00A5);
        bus_read(io_addr(IO_PPI, 2'd1), rd);
        check_word("port B", rd, 16'hFFA5);
        write_portc(PPI_C_RESET);
        bus_write(io_addr(IO_MUTE, 2'd0), 16'h0000);
        check_byte("mute", {7'b0, mute}, 8'h01);
        bus_write(io_addr(IO_MUTE, 2'd0), 16'h0080);
        check_byte("mute", {7'b0, mute}, 8'h00);
        tc = toggle_count;
        bus_write(io_addr(IO_TOGGLE, 2'd0), 16'h0000);
        if (toggle_count != tc + 1) begin
            errors++;
            $display("obj_toggle gave %0d pulse cycles instead of one", toggle_count - tc);
        end
    endtask

    task automatic adc_conversion;
        byte_t joys [5] = '{8'hFF, 8'hFE, 8'hFC, 8'hEF, 8'hDF};
        word_t a, b, rd;
        for (int ty = 0; ty < 8; ty++) begin
            for (int k = 0; k < 5; k++) begin
                a = word_t'(rand_bits(16));
                b = word_t'(rand_bits(16));
                @(posedge clk);
                ctrl_type <= 3'(ty);
                joystick1 <= joys[k];
                joyana1   <= a;
                joyana1b  <= b;
                bus_write(io_addr(IO_ADC, 2'd0), 16'h0000);   // Latch
                @(posedge clk);
                joyana1   <= ~a;   // Reads come from the latched copy
                joyana1b  <= ~b;
                for (int ch = 0; ch < 3; ch++) begin
                    write_portc({3'b001, 3'(ch), 2'b01});
                    bus_read(io_addr(IO_ADC, 2'd0), rd);
                    check_word("adc", rd, {8'hFF, adc_expect(3'(ch), 3'(ty), a, b, joys[k])});
                end
            end
        end
    endtask

    task automatic motor_steps(input byte_t ctrl, input int n, input logic [2:0] lim);
        int s;
        word_t rd;
        bus_write(io_addr(IO_PPI, 2'd1), {8'h00, ctrl});
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            vint <= 1'b1;
            @(posedge clk);
            vint <= 1'b0;
            s = int'(mpos) + int'($signed(ctrl)) * 256;
            if (s < int'(MOTOR_MIN)) s = int'(MOTOR_MIN);
            if (s > int'(MOTOR_MAX)) s = int'(MOTOR_MAX);
            mpos = word_t'(s);
        end
        bus_read(io_addr(IO_ADC, 2'd0), rd);
        check_word("motor adc", rd, {8'hFF, mpos[15:8]});
        bus_read(io_addr(IO_PPI, 2'd0), rd);
        check_word("port A", rd, {8'hFF, 2'b00, lim, 3'b111});
    endtask

    task automatic motor_travel;
        mpos = MOTOR_CENTRE;
        write_portc({3'b001, ADC_MOTOR, 2'b01});
        motor_steps(8'h40, 2, 3'b100);   // Up to the max stop
        motor_steps(8'hC0, 4, 3'b001);   // Down past the min stop
        motor_steps(8'h60, 1, 3'b010);   // Back to centre
        motor_steps(8'h00, 1, 3'b010);
    endtask

    initial begin
        rst = 1'b1;
        vint = 1'b0;
        req = 1'b0;
        addr = '0;
        rnw = 1'b1;
        wdata = '0;
        dsn = 2'b11;
        rom_data = '0;
        ram_data = '0;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        char_dout = '0;
        pal_dout = '0;
        obj_dout = '0;
        ctrl_type = 3'd0;
        joystick1 = 8'hFF;
        joyana1 = '0;
        joyana1b = '0;
        start_button = 2'b00;
        coin_input = 2'b00;
        service = 1'b0;
        dip_test = 1'b0;
        dipsw_a = 8'h00;
        dipsw_b = 8'h00;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_values;
        memory_map_reads;
        switch_and_control_io;
        adc_conversion;
        motor_travel;
        repeat (2) @(posedge clk);
        $display("Checks done: %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
